/* Makefile */
# Verilator build and run for the SD card SPI reader

VERILATOR ?= verilator
TOP       ?= tb_sd_spi_reader
FILELIST  ?= sd_spi_reader.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/sd_controller.sv */
`timescale 1ns/100ps

module sd_controller #(
  parameter int POLL_LIMIT = 8
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 rd_stb,
  input  sd_pkg::sd_read_req_t rd_req,
  output logic                 ready,
  output logic                 data_stb,
  output sd_pkg::sd_byte_t     data,
  output logic                 rd_done,
  output sd_pkg::sd_xfer_req_t xfer_req,
  input  sd_pkg::sd_xfer_rsp_t xfer_rsp
);

  import sd_pkg::*;

  typedef enum logic {
    INIT,
    OPERATE
  } phase_e;

  phase_e       phase_q;
  logic         booted_q;
  logic         start_q;
  logic         init_done;
  logic         rd_busy;
  sd_xfer_req_t init_req;
  sd_xfer_req_t read_req;

  assign ready    = (phase_q == OPERATE) && !rd_busy;
  assign xfer_req = (phase_q == INIT) ? init_req : read_req;

  // init kicks off once, the cycle after reset drops
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase_q  <= INIT;
      booted_q <= 1'b0;
      start_q  <= 1'b0;
    end else begin
      booted_q <= 1'b1;
      start_q  <= !booted_q;
      if (init_done) phase_q <= OPERATE;
    end
  end

  sd_init_seq u_init (
    .CLK   (CLK),
    .RST   (RST),
    .start (start_q),
    .req   (init_req),
    .rsp   (xfer_rsp),
    .done  (init_done)
  );

  sd_read_seq #(
    .POLL_LIMIT (POLL_LIMIT)
  ) u_read (
    .CLK      (CLK),
    .RST      (RST),
    .rd_stb   (rd_stb && ready),
    .rd_req   (rd_req),
    .req      (read_req),
    .rsp      (xfer_rsp),
    .data_stb (data_stb),
    .data     (data),
    .rd_done  (rd_done),
    .busy     (rd_busy)
  );

endmodule

/* hw/sd_init_seq.sv */
`timescale 1ns/100ps

module sd_init_seq (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  output sd_pkg::sd_xfer_req_t req,
  input  sd_pkg::sd_xfer_rsp_t rsp,
  output logic                 done
);

  import sd_pkg::*;

  typedef enum logic [2:0] {
    I_WAIT,
    I_DUMMY,
    I_CMD0,
    I_CMD8,
    I_R7,
    I_CMD55,
    I_ACMD41,
    I_DONE
  } i_state_e;

  i_state_e   state_q;
  logic       pend_q;
  logic [3:0] cnt_q;
  logic       hit;

  // only our own operation completes here
  assign hit  = pend_q && rsp.done;
  assign done = (state_q == I_DONE);

  always_comb begin
    req.stb = !pend_q && (state_q != I_WAIT) && (state_q != I_DONE);
    case (state_q)
      I_DUMMY: req.op = IDLE_BYTE;
      I_R7:    req.op = DATA_BYTE;
      default: req.op = COMMAND;
    endcase
    case (state_q)
      I_CMD0:   req.cmd = '{index: CMD0, arg: 32'h0000_0000, crc: 8'h95};
      I_CMD8:   req.cmd = '{index: CMD8, arg: 32'h0000_01AA, crc: 8'h87};
      I_CMD55:  req.cmd = '{index: CMD55, arg: 32'h0000_0000, crc: 8'h65};
      I_ACMD41: req.cmd = '{index: ACMD41, arg: 32'h4000_0000, crc: 8'h77};
      default:  req.cmd = '{index: CMD0, arg: 32'hFFFF_FFFF, crc: 8'hFF};
    endcase
  end

  // staying in a state after a hit reissues its operation
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= I_WAIT;
      pend_q  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      if (req.stb) begin
        pend_q <= 1'b1;
      end else if (hit) begin
        pend_q <= 1'b0;
      end
      case (state_q)
        I_WAIT: begin
          if (start) begin
            state_q <= I_DUMMY;
            cnt_q   <= '0;
          end
        end
        I_DUMMY: begin
          if (hit) begin
            cnt_q <= cnt_q + 4'd1;
            if (cnt_q == 4'd9) state_q <= I_CMD0;
          end
        end
        I_CMD0: begin
          if (hit && !rsp.timeout && rsp.data == R1_IDLE) state_q <= I_CMD8;
        end
        I_CMD8: begin
          if (hit && !rsp.timeout && rsp.data == R1_IDLE) begin
            state_q <= I_R7;
            cnt_q   <= '0;
          end
        end
        I_R7: begin
          // four trailing bytes, check pattern in the last
          if (hit) begin
            cnt_q <= cnt_q + 4'd1;
            if (cnt_q == 4'd3) state_q <= (rsp.data == CMD8_ECHO) ? I_CMD55 : I_CMD8;
          end
        end
        I_CMD55: begin
          if (hit && !rsp.timeout && rsp.data[7:1] == 7'd0) state_q <= I_ACMD41;
        end
        I_ACMD41: begin
          if (hit) state_q <= (!rsp.timeout && rsp.data == R1_READY) ? I_DONE : I_CMD55;
        end
        default: state_q <= I_WAIT;
      endcase
    end
  end

endmodule

/* hw/sd_pkg.sv */
package sd_pkg;

  // ------------------------------------------------------------
  // link widths and sizes
  // ------------------------------------------------------------
  typedef logic [7:0] sd_byte_t;

  localparam int SD_ADDR_WIDTH   = 32;
  localparam int SD_BLKCNT_WIDTH = 16;
  localparam int SD_BLOCK_BYTES  = 512;

  // command index as it sits in the frame after the start bits
  typedef enum logic [5:0] {
    CMD0   = 6'd0,
    CMD8   = 6'd8,
    CMD12  = 6'd12,
    CMD18  = 6'd18,
    ACMD41 = 6'd41,
    CMD55  = 6'd55
  } sd_cmd_e;

  typedef struct packed {
    sd_cmd_e     index;
    logic [31:0] arg;
    sd_byte_t    crc;
  } sd_command_t;

  // ------------------------------------------------------------
  // sequencer to transactor link
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE_BYTE = 2'd0,
    COMMAND   = 2'd1,
    DATA_BYTE = 2'd2
  } sd_xfer_op_e;

  typedef struct packed {
    logic        stb;
    sd_xfer_op_e op;
    sd_command_t cmd;
  } sd_xfer_req_t;

  typedef struct packed {
    logic     done;
    logic     timeout;
    sd_byte_t data;
  } sd_xfer_rsp_t;

  typedef struct packed {
    logic [SD_ADDR_WIDTH-1:0]   addr;
    logic [SD_BLKCNT_WIDTH-1:0] count;
  } sd_read_req_t;

  // response and token bytes
  localparam sd_byte_t R1_IDLE     = 8'h01;
  localparam sd_byte_t R1_READY    = 8'h00;
  localparam sd_byte_t TOKEN_START = 8'hFE;
  localparam sd_byte_t CMD8_ECHO   = 8'hAA;

endpackage

/* hw/sd_read_seq.sv */
`timescale 1ns/100ps

module sd_read_seq #(
  parameter int POLL_LIMIT = 8
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 rd_stb,
  input  sd_pkg::sd_read_req_t rd_req,
  output sd_pkg::sd_xfer_req_t req,
  input  sd_pkg::sd_xfer_rsp_t rsp,
  output logic                 data_stb,
  output sd_pkg::sd_byte_t     data,
  output logic                 rd_done,
  output logic                 busy
);

  import sd_pkg::*;

  // token wait allowance, in polled bytes
  localparam int TOKEN_LIMIT = POLL_LIMIT * 64;
  localparam int TW = $clog2(TOKEN_LIMIT);
  localparam int BW = $clog2(SD_BLOCK_BYTES);

  typedef enum logic [2:0] {
    R_IDLE,
    R_CMD18,
    R_TOKEN,
    R_DATA,
    R_CRC,
    R_CMD12,
    R_BUSY,
    R_FINISH
  } r_state_e;

  r_state_e                   state_q;
  logic                       pend_q;
  logic                       hit;
  logic [SD_ADDR_WIDTH-1:0]   addr_q;
  logic [SD_BLKCNT_WIDTH-1:0] left_q;
  logic [BW-1:0]              byte_q;
  logic [TW-1:0]              wait_q;

  assign hit      = pend_q && rsp.done;
  assign data_stb = hit && (state_q == R_DATA);
  assign data     = rsp.data;
  assign rd_done  = (state_q == R_FINISH);
  assign busy     = (state_q != R_IDLE);

  always_comb begin
    req.stb = !pend_q && (state_q != R_IDLE) && (state_q != R_FINISH);
    req.op  = DATA_BYTE;
    req.cmd = '{index: CMD18, arg: addr_q, crc: 8'hFF};
    if (state_q == R_CMD18) begin
      req.op = COMMAND;
    end
    if (state_q == R_CMD12) begin
      req.op  = COMMAND;
      req.cmd = '{index: CMD12, arg: 32'h0000_0000, crc: 8'h61};
    end
  end

  // ------------------------------------------------------------
  // block loop, a lost token stops and resumes at the same block
  // ------------------------------------------------------------
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= R_IDLE;
      pend_q  <= 1'b0;
      addr_q  <= '0;
      left_q  <= '0;
      byte_q  <= '0;
      wait_q  <= '0;
    end else begin
      if (req.stb) begin
        pend_q <= 1'b1;
      end else if (hit) begin
        pend_q <= 1'b0;
      end
      case (state_q)
        R_IDLE: begin
          if (rd_stb) begin
            addr_q  <= rd_req.addr;
            left_q  <= rd_req.count;
            state_q <= (rd_req.count == '0) ? R_FINISH : R_CMD18;
          end
        end
        R_CMD18: begin
          if (hit && !rsp.timeout && rsp.data == R1_READY) begin
            state_q <= R_TOKEN;
            wait_q  <= '0;
          end
        end
        R_TOKEN: begin
          if (hit && rsp.data == TOKEN_START) begin
            state_q <= R_DATA;
            byte_q  <= '0;
          end else if (hit && wait_q == TW'(TOKEN_LIMIT - 1)) begin
            state_q <= R_CMD12;
          end else if (hit) begin
            wait_q <= wait_q + 1'b1;
          end
        end
        R_DATA: begin
          if (hit) begin
            byte_q <= byte_q + 1'b1;
            if (byte_q == BW'(SD_BLOCK_BYTES - 1)) state_q <= R_CRC;
          end
        end
        R_CRC: begin
          // two crc bytes, dropped
          if (hit) begin
            byte_q <= byte_q + 1'b1;
            if (byte_q == BW'(1)) begin
              addr_q  <= addr_q + 1'b1;
              left_q  <= left_q - 1'b1;
              wait_q  <= '0;
              state_q <= (left_q == SD_BLKCNT_WIDTH'(1)) ? R_CMD12 : R_TOKEN;
            end
          end
        end
        R_CMD12: begin
          if (hit && !rsp.timeout) state_q <= R_BUSY;
        end
        R_BUSY: begin
          // card holds the line at zero while busy
          if (hit && rsp.data != 8'h00) state_q <= (left_q == '0) ? R_FINISH : R_CMD18;
        end
        default: state_q <= R_IDLE;
      endcase
    end
  end

endmodule

/* hw/sd_spi_reader.sv */
`timescale 1ns/100ps

module sd_spi_reader #(
  parameter int CLK_DIV    = 4,
  parameter int POLL_LIMIT = 8
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 rd_stb,
  input  sd_pkg::sd_read_req_t rd_req,
  output logic                 ready,
  output logic                 data_stb,
  output sd_pkg::sd_byte_t     data,
  output logic                 rd_done,
  output logic                 sclk,
  output logic                 mosi,
  input  logic                 miso,
  output logic                 cs
);

  import sd_pkg::*;

  sd_xfer_req_t xfer_req;
  sd_xfer_rsp_t xfer_rsp;

  sd_controller #(
    .POLL_LIMIT (POLL_LIMIT)
  ) u_ctrl (
    .CLK      (CLK),
    .RST      (RST),
    .rd_stb   (rd_stb),
    .rd_req   (rd_req),
    .ready    (ready),
    .data_stb (data_stb),
    .data     (data),
    .rd_done  (rd_done),
    .xfer_req (xfer_req),
    .xfer_rsp (xfer_rsp)
  );

  sd_transactor #(
    .CLK_DIV    (CLK_DIV),
    .POLL_LIMIT (POLL_LIMIT)
  ) u_xact (
    .CLK  (CLK),
    .RST  (RST),
    .req  (xfer_req),
    .rsp  (xfer_rsp),
    .cs   (cs),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso)
  );

endmodule

/* hw/sd_transactor.sv */
`timescale 1ns/100ps

module sd_transactor #(
  parameter int CLK_DIV    = 4,
  parameter int POLL_LIMIT = 8
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  sd_pkg::sd_xfer_req_t req,
  output sd_pkg::sd_xfer_rsp_t rsp,
  output logic                 cs,
  output logic                 sclk,
  output logic                 mosi,
  input  logic                 miso
);

  import sd_pkg::*;

  localparam int PW = $clog2(POLL_LIMIT + 1);

  typedef enum logic [1:0] {
    T_IDLE,
    T_FRAME,
    T_POLL,
    T_SINGLE
  } t_state_e;

  t_state_e      state_q;
  logic [39:0]   frame_q;
  logic [2:0]    left_q;
  logic [PW-1:0] poll_q;
  logic          byte_stb_q;
  sd_byte_t      tx_q;
  logic          rx_stb;
  sd_byte_t      rx_byte;
  logic          done_q;
  logic          timeout_q;
  sd_byte_t      data_q;

  assign rsp = '{done: done_q, timeout: timeout_q, data: data_q};

  // ------------------------------------------------------------
  // operation control and chip select
  // ------------------------------------------------------------
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q    <= T_IDLE;
      left_q     <= '0;
      poll_q     <= '0;
      byte_stb_q <= 1'b0;
      cs         <= 1'b1;
      done_q     <= 1'b0;
      timeout_q  <= 1'b0;
    end else begin
      byte_stb_q <= 1'b0;
      done_q     <= 1'b0;
      case (state_q)
        T_IDLE: begin
          if (req.stb) begin
            byte_stb_q <= 1'b1;
            cs         <= (req.op == IDLE_BYTE);
            timeout_q  <= 1'b0;
            left_q     <= 3'd5;
            state_q    <= (req.op == COMMAND) ? T_FRAME : T_SINGLE;
          end
        end
        T_FRAME: begin
          if (rx_stb) begin
            byte_stb_q <= 1'b1;
            if (left_q == 3'd0) begin
              state_q <= T_POLL;
              poll_q  <= '0;
            end else begin
              left_q <= left_q - 3'd1;
            end
          end
        end
        T_POLL: begin
          // R1 starts with a clear top bit
          if (rx_stb && (!rx_byte[7] || poll_q == PW'(POLL_LIMIT - 1))) begin
            done_q    <= 1'b1;
            timeout_q <= rx_byte[7];
            state_q   <= T_IDLE;
          end else if (rx_stb) begin
            poll_q     <= poll_q + 1'b1;
            byte_stb_q <= 1'b1;
          end
        end
        default: begin
          if (rx_stb) begin
            done_q  <= 1'b1;
            state_q <= T_IDLE;
          end
        end
      endcase
    end
  end

  // frame serializer, start bits plus index go first
  always_ff @(posedge CLK) begin
    if (state_q == T_IDLE && req.stb) begin
      tx_q    <= (req.op == COMMAND) ? {2'b01, req.cmd.index} : 8'hFF;
      frame_q <= {req.cmd.arg, req.cmd.crc};
    end else if (rx_stb) begin
      tx_q    <= (state_q == T_FRAME && left_q != 3'd0) ? frame_q[39:32] : 8'hFF;
      frame_q <= {frame_q[31:0], 8'hFF};
      data_q  <= rx_byte;
    end
  end

  spi_byte_engine #(
    .CLK_DIV (CLK_DIV)
  ) u_engine (
    .CLK      (CLK),
    .RST      (RST),
    .byte_stb (byte_stb_q),
    .tx_byte  (tx_q),
    .rx_stb   (rx_stb),
    .rx_byte  (rx_byte),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso)
  );

endmodule

/* hw/spi_byte_engine.sv */
`timescale 1ns/100ps

module spi_byte_engine #(
  parameter int CLK_DIV = 4
) (
  input  logic             CLK,
  input  logic             RST,
  input  logic             byte_stb,
  input  sd_pkg::sd_byte_t tx_byte,
  output logic             rx_stb,
  output sd_pkg::sd_byte_t rx_byte,
  output logic             sclk,
  output logic             mosi,
  input  logic             miso
);

  localparam int TW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic          busy_q;
  logic [TW-1:0] tick_q;
  logic [3:0]    half_q;
  logic [7:0]    tx_q;
  logic [7:0]    rx_q;
  logic          tick;

  // end of one sclk half period
  assign tick = busy_q && (tick_q == TW'(CLK_DIV - 1));

  // line idles high between bytes
  assign mosi    = busy_q ? tx_q[7] : 1'b1;
  assign rx_byte = rx_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q <= 1'b0;
      tick_q <= '0;
      half_q <= '0;
      sclk   <= 1'b0;
      rx_stb <= 1'b0;
    end else begin
      rx_stb <= 1'b0;
      if (byte_stb && !busy_q) begin
        busy_q <= 1'b1;
        tick_q <= '0;
        half_q <= '0;
      end else if (tick) begin
        tick_q <= '0;
        half_q <= half_q + 4'd1;
        // even half periods rise, odd ones fall
        sclk   <= ~half_q[0];
        if (half_q == 4'd15) begin
          busy_q <= 1'b0;
          rx_stb <= 1'b1;
        end
      end else if (busy_q) begin
        tick_q <= tick_q + 1'b1;
      end
    end
  end

  // sample on the rising edge, shift out on the falling edge
  always_ff @(posedge CLK) begin
    if (byte_stb && !busy_q) begin
      tx_q <= tx_byte;
    end else if (tick && half_q[0]) begin
      tx_q <= {tx_q[6:0], 1'b1};
    end else if (tick) begin
      rx_q <= {rx_q[6:0], miso};
    end
  end

endmodule

/* sd_spi_reader.f */
hw/sd_pkg.sv
hw/spi_byte_engine.sv
hw/sd_transactor.sv
hw/sd_init_seq.sv
hw/sd_read_seq.sv
hw/sd_controller.sv
hw/sd_spi_reader.sv
test/sd_card_model.sv
test/sd_spi_reader_props.sv
test/tb_sd_spi_reader.sv

/* test/sd_card_model.sv */
`timescale 1ns/100ps

module sd_card_model #(
  parameter bit SILENT_CMD0 = 1'b1,
  parameter int IDLE_ACMD41 = 3
) (
  input  logic sclk,
  input  logic mosi,
  input  logic cs,
  output logic miso
);

  logic [7:0]  out_q       = 8'hFF;
  logic [7:0]  in_q        = 8'hFF;
  int          bits        = 0;
  logic [47:0] frame_q     = '0;
  int          frame_n     = 0;
  int          gap_n       = 0;
  int          cmd0_seen   = 0;
  int          acmd41_seen = 0;
  bit          ready_sent  = 1'b0;
  bit          reading     = 1'b0;
  bit          selected    = 1'b0;
  int          idle_edges  = 0;
  logic [31:0] rd_blk      = '0;
  logic [7:0]  tx_fifo[$];

  // command log, read back by the testbench
  logic [5:0]  log_idx[$];
  logic [31:0] log_arg[$];
  logic [7:0]  log_crc[$];

  assign miso = cs ? 1'b1 : out_q[7];

  function automatic logic [7:0] block_pattern(input logic [31:0] b, input int k);
    logic [31:0] v;
    v = (b + 32'(k)) ^ (b >> 8);
    return v[7:0];
  endfunction

  task automatic queue_response(input logic [7:0] r);
    // fill bytes cycle through 1 to 4
    repeat (1 + gap_n % 4) tx_fifo.push_back(8'hFF);
    gap_n++;
    tx_fifo.push_back(r);
  endtask

  task automatic queue_block();
    queue_response(8'hFE);
    for (int k = 0; k < 512; k++) begin
      tx_fifo.push_back(block_pattern(rd_blk, k));
    end
    // crc bytes, host drops them
    tx_fifo.push_back(8'h5A);
    tx_fifo.push_back(8'hA5);
    rd_blk++;
  endtask

  // ------------------------------------------------------------
  // command decode
  // ------------------------------------------------------------
  task automatic run_command(input logic [47:0] f);
    logic [5:0]  idx;
    logic [31:0] arg;
    idx = f[45:40];
    arg = f[39:8];
    log_idx.push_back(idx);
    log_arg.push_back(arg);
    log_crc.push_back(f[7:0]);
    case (idx)
      6'd0: begin
        cmd0_seen++;
        if (!(SILENT_CMD0 && cmd0_seen == 1)) queue_response(8'h01);
      end
      6'd8: begin
        // R7 tail echoes voltage and check pattern
        queue_response(8'h01);
        tx_fifo.push_back(8'h00);
        tx_fifo.push_back(8'h00);
        tx_fifo.push_back({4'h0, arg[11:8]});
        tx_fifo.push_back(arg[7:0]);
      end
      6'd55: queue_response(ready_sent ? 8'h00 : 8'h01);
      6'd41: begin
        acmd41_seen++;
        ready_sent = (acmd41_seen > IDLE_ACMD41);
        queue_response(ready_sent ? 8'h00 : 8'h01);
      end
      6'd18: begin
        tx_fifo.delete();
        queue_response(8'h00);
        rd_blk  = arg;
        reading = 1'b1;
        queue_block();
      end
      6'd12: begin
        reading = 1'b0;
        tx_fifo.delete();
        queue_response(8'h00);
        // busy, then released
        repeat (3) tx_fifo.push_back(8'h00);
        tx_fifo.push_back(8'hFF);
      end
      default: queue_response(8'h05);
    endcase
  endtask

  task automatic take_byte(input logic [7:0] b);
    if (frame_n > 0 || b[7:6] == 2'b01) begin
      frame_q = {frame_q[39:0], b};
      frame_n++;
      if (frame_n == 6) begin
        frame_n = 0;
        run_command(frame_q);
      end
    end
  endtask

  // mode 0, sample on rise
  always @(posedge sclk) begin
    if (cs) begin
      if (!selected) idle_edges++;
    end else begin
      selected = 1'b1;
      in_q     = {in_q[6:0], mosi};
      bits++;
    end
  end

  // shift on fall, next byte loaded on the eighth fall
  always @(negedge sclk) begin
    if (!cs && bits == 8) begin
      bits = 0;
      take_byte(in_q);
      if (tx_fifo.size() == 0 && reading) queue_block();
      if (tx_fifo.size() > 0) begin
        out_q = tx_fifo.pop_front();
      end else begin
        out_q = 8'hFF;
      end
    end else if (!cs) begin
      out_q = {out_q[6:0], 1'b1};
    end
  end

endmodule

/* test/sd_spi_reader_props.sv */
`timescale 1ns/100ps

module sd_spi_reader_props (
  input logic CLK,
  input logic RST,
  input logic cs,
  input logic sclk,
  input logic ready,
  input logic data_stb,
  input logic rd_done
);

  int   fail_count = 0;
  logic selected_q;

  // first low cs ends the dummy bytes
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      selected_q <= 1'b0;
    end else if (!cs) begin
      selected_q <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // link and handshake rules
  // ------------------------------------------------------------
  sclk_quiet: assert property (@(posedge CLK) disable iff (RST) (cs && selected_q) |-> !sclk)
    else begin
      fail_count++;
      $error("sclk toggled while cs was high after the dummy bytes");
    end

  stb_done_apart: assert property (@(posedge CLK) disable iff (RST) !(data_stb && rd_done))
    else begin
      fail_count++;
      $error("data_stb and rd_done were high in the same cycle");
    end

  ready_in_reset: assert property (@(posedge CLK) RST |-> !ready)
    else begin
      fail_count++;
      $error("ready was high during reset");
    end

endmodule

/* test/tb_sd_spi_reader.sv */
`timescale 1ns/100ps

module tb_sd_spi_reader;

  import sd_pkg::*;

  localparam int CLK_DIV    = 2;
  localparam int POLL_LIMIT = 8;
  localparam int N_READS    = 4;
  // byte budgets for init and for one read of up to three blocks
  localparam int INIT_BYTES = 200;
  localparam int READ_BYTES = 1600;
  localparam int WATCHDOG_CYCLES = 3 * (INIT_BYTES + N_READS * READ_BYTES) * 32 * CLK_DIV;

  logic         CLK;
  logic         RST;
  logic         rd_stb;
  sd_read_req_t rd_req;
  logic         ready;
  logic         data_stb;
  sd_byte_t     data;
  logic         rd_done;
  logic         sclk;
  logic         mosi;
  logic         miso;
  logic         cs;

  int           errors;
  int           stb_count;
  int           total_stb;
  int           expected_total;
  bit           in_read;
  logic [31:0]  exp_addr;
  logic [31:0]  rng;
  logic [31:0]  addr;
  int           blocks;

  sd_spi_reader #(
    .CLK_DIV    (CLK_DIV),
    .POLL_LIMIT (POLL_LIMIT)
  ) UUT (
    .CLK      (CLK),
    .RST      (RST),
    .rd_stb   (rd_stb),
    .rd_req   (rd_req),
    .ready    (ready),
    .data_stb (data_stb),
    .data     (data),
    .rd_done  (rd_done),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .cs       (cs)
  );

  // silent first CMD0, three idle ACMD41 answers
  sd_card_model #(
    .SILENT_CMD0 (1'b1),
    .IDLE_ACMD41 (3)
  ) u_card (
    .sclk (sclk),
    .mosi (mosi),
    .cs   (cs),
    .miso (miso)
  );

  bind sd_spi_reader sd_spi_reader_props u_props (
    .CLK      (CLK),
    .RST      (RST),
    .cs       (cs),
    .sclk     (sclk),
    .ready    (ready),
    .data_stb (data_stb),
    .rd_done  (rd_done)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] expected_byte(input logic [31:0] b, input int k);
    logic [31:0] v;
    v = (b + 32'(k)) ^ (b >> 8);
    return v[7:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ------------------------------------------------------------
  // init order from the card's command log
  // ------------------------------------------------------------
  task automatic check_init();
    int          n;
    logic [5:0]  exp_idx;
    logic [31:0] exp_arg;
    n = u_card.log_idx.size();
    assert (n == 11) else begin
      errors++;
      $display("init issued %0d commands where 11 were due", n);
    end
    for (int i = 0; i < n && i < 11; i++) begin
      if (i < 2) begin
        exp_idx = 6'd0;
      end else if (i == 2) begin
        exp_idx = 6'd8;
      end else if (i % 2 == 1) begin
        exp_idx = 6'd55;
      end else begin
        exp_idx = 6'd41;
      end
      exp_arg = (i == 2) ? 32'h0000_01AA : (exp_idx == 6'd41) ? 32'h4000_0000 : 32'h0;
      check_value($sformatf("cmd[%0d] index", i), u_card.log_idx[i], exp_idx);
      check_value($sformatf("cmd[%0d] arg", i), u_card.log_arg[i], exp_arg);
    end
    if (n > 2) check_value("cmd8 crc", u_card.log_crc[2], 8'h87);
    assert (u_card.idle_edges >= 80) else begin
      errors++;
      $display("only %0d sclk edges with cs high before the first command", u_card.idle_edges);
    end
  endtask

  task automatic run_read(input logic [31:0] a, input int nblk);
    int first;
    first          = u_card.log_idx.size();
    exp_addr       = a;
    stb_count      = 0;
    expected_total = expected_total + 512 * nblk;
    @(posedge CLK);
    #2;
    rd_req  = '{addr: a, count: 16'(nblk)};
    rd_stb  = 1'b1;
    in_read = 1'b1;
    @(posedge CLK);
    #2;
    rd_stb = 1'b0;
    do @(negedge CLK); while (!rd_done);
    in_read = 1'b0;
    check_value("data_stb count", stb_count, 512 * nblk);
    check_value("ready with rd_done", ready, 1'b0);
    @(negedge CLK);
    check_value("rd_done after one cycle", rd_done, 1'b0);
    check_value("ready after rd_done", ready, 1'b1);
    check_value("read command count", u_card.log_idx.size() - first, 2);
    if (u_card.log_idx.size() >= first + 2) begin
      check_value("read cmd index", u_card.log_idx[first], 6'd18);
      check_value("read cmd arg", u_card.log_arg[first], a);
      check_value("stop cmd index", u_card.log_idx[first + 1], 6'd12);
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge CLK) begin
    if (!RST && data_stb) begin
      check_value("data", data, expected_byte(exp_addr + stb_count / 512, stb_count % 512));
      stb_count++;
      total_stb++;
    end
    if (in_read) begin
      assert (!cs) else begin
        errors++;
        $display("cs went high during a read at %0t", $time);
      end
    end
    if (!RST && ready) begin
      assert (u_card.ready_sent) else begin
        errors++;
        $display("ready rose before ACMD41 answered ready at %0t", $time);
      end
    end
  end

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout, the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    RST            = 1'b1;
    rd_stb         = 1'b0;
    rd_req         = '0;
    errors         = 0;
    stb_count      = 0;
    total_stb      = 0;
    expected_total = 0;
    in_read        = 1'b0;
    exp_addr       = '0;
    rng            = 32'h2d75_b317;
    repeat (2) @(posedge CLK);
    #2;
    RST = 1'b0;
    // a request during init, while ready is low, must be dropped
    repeat (4) @(posedge CLK);
    #2;
    rd_req = '{addr: 32'h0000_0100, count: 16'd2};
    rd_stb = 1'b1;
    @(posedge CLK);
    #2;
    rd_stb = 1'b0;
    do @(negedge CLK); while (!ready);
    check_init();
    for (int i = 0; i < N_READS; i++) begin
      rng    = lcg_step(rng);
      addr   = rng;
      rng    = lcg_step(rng);
      blocks = 1 + int'(rng[31:16] % 16'd3);
      run_read(addr, blocks);
    end
    // quiet period, no stray strobes
    repeat (200) @(negedge CLK);
    check_value("total data_stb", total_stb, expected_total);
    $display("errors: %0d in testbench checks, %0d in protocol checks",
             errors, UUT.u_props.fail_count);
    if (errors == 0 && UUT.u_props.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
